/* compile.f */
logic/zports_pkg.sv
logic/io_cycle_detect.sv
logic/port_decode.sv
logic/sound_border.sv
logic/ide_bridge.sv
logic/mem_paging.sv
logic/zports_top.sv
tb/tb_zports.sv

/* logic/ide_bridge.sv */
//////////////////////////////////////////////////
// 8-to-16 bit IDE bridge
// normal 10/11 and nemo-divide 10/10 sequencing
//////////////////////////////////////////////////
module ide_bridge import zports_pkg::*; (
	input  logic        zclk,
	input  logic        rst_n,
	input  zbus_t       bus,
	input  port_sel_e   sel,
	input  logic        port_wr,
	input  logic        port_rd,
	input  logic [7:0]  din,
	input  logic [15:0] idein,
	output ide_ctl_t    ide,
	output logic [15:0] ideout,
	output logic [7:0]  rd_data
);

	// normal read:  10(lo), 11(hi)    divide read:  10(lo), 10(hi)
	// normal write: 11(hi), 10(lo)    divide write: 10(lo), 10(hi)

	logic        ide_ports; // physical drive registers, 11 excluded
	logic        ide_any;   // any ide port incl 11
	logic        ide_acc;   // strobe on any ide port
	logic        is_lo, is_hi;
	logic        rd_trig, wrlo_trig, wrhi_trig; // nemo triggers
	logic        rd_latch, wrlo_latch, wrhi_latch; // held through the cycle
	logic [7:0]  hi_in;     // latched high byte from drive
	logic [15:0] wr_reg;    // pre-written half of output word

	assign is_lo     = (sel == PS_IDE_LO);
	assign is_hi     = (sel == PS_IDE_HI);
	assign ide_ports = is_lo || (sel == PS_IDE_REG);
	assign ide_any   = ide_ports || is_hi;
	assign ide_acc   = ide_any && (port_rd || port_wr);

	//////////////////////////////////////////////////
	// triggers
	//////////////////////////////////////////////////
	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
			rd_trig <= 1'b0;
		else if (is_lo && port_rd && !rd_trig)
			rd_trig <= 1'b1; // first read of 10
		else if (ide_acc)
			rd_trig <= 1'b0;
	end

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			wrhi_trig <= 1'b0;
			wrlo_trig <= 1'b0;
		end
		else if (ide_acc)
		begin
			wrhi_trig <= is_hi && port_wr;
			wrlo_trig <= is_lo && port_wr && !wrhi_trig && !wrlo_trig; // divide, 1st byte
		end
	end

	// data registers
	always_ff @(posedge zclk)
	begin
		if (port_wr && is_hi)
			wr_reg[15:8] <= din;
		if (port_wr && is_lo && !wrlo_trig)
			wr_reg[7:0] <= din;
		if (port_rd && is_lo && !rd_trig)
			hi_in <= idein[15:8]; // keep high half for 11 or 2nd 10
	end

	// triggers change mid-cycle, so hold them while the strobe is low
	always_latch
	begin
		if (bus.rd_n)
			rd_latch <= rd_trig;
	end

	always_latch
	begin
		if (bus.wr_n)
		begin
			wrlo_latch <= wrlo_trig;
			wrhi_latch <= wrhi_trig;
		end
	end

	//////////////////////////////////////////////////
	// drive side
	//////////////////////////////////////////////////
	assign ide.ide_a = bus.a[7:5];
	assign ide.cs0_n = ~(ide_ports && (bus.a[7:0] != IDE_C8));
	assign ide.cs1_n = ~(ide_ports && (bus.a[7:0] == IDE_C8));

	// no drive read for divide 2nd byte
	assign ide.rd_n = bus.iorq_n | bus.rd_n | ~ide_ports | (rd_latch && is_lo);
	// no drive write for divide 1st byte
	assign ide.wr_n = bus.iorq_n | bus.wr_n | ~ide_ports |
		(is_lo && !wrlo_latch && !wrhi_latch);
	assign ide.dataout_n = ide.rd_n;

	assign ideout[15:8] = wrhi_latch ? wr_reg[15:8] : din;
	assign ideout[7:0]  = wrlo_latch ? wr_reg[7:0]  : din;

	// z80 read data
	always_comb
	begin
		if (is_hi || (rd_latch && is_lo))
			rd_data = hi_in;
		else
			rd_data = idein[7:0];
	end

	// second byte of a divide read never reaches the drive
	a_divide_rd: assert property (@(posedge zclk) disable iff (!rst_n)
		(port_rd && is_lo && rd_trig) |-> ide.rd_n);

endmodule

/* logic/io_cycle_detect.sv */
//////////////////////////////////////////////////
// I/O cycle detector
// one-cycle read and write strobes per io cycle
//////////////////////////////////////////////////
module io_cycle_detect import zports_pkg::*; (
	input  logic  zclk,
	input  logic  rst_n,
	input  zbus_t bus,
	output logic  port_wr,
	output logic  port_rd
);

	logic wr_now, rd_now; // active levels right now
	logic wr_prev, rd_prev; // levels at previous edge

	assign wr_now = ~(bus.iorq_n | bus.wr_n);
	assign rd_now = ~(bus.iorq_n | bus.rd_n);

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_prev <= 1'b0;
			rd_prev <= 1'b0;
			port_wr <= 1'b0;
			port_rd <= 1'b0;
		end
		else
		begin
			wr_prev <= wr_now;
			rd_prev <= rd_now;
			port_wr <= wr_now & ~wr_prev; // leading edge only
			port_rd <= rd_now & ~rd_prev;
		end
	end

	// z80 never reads and writes in one io cycle
	a_strobe_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr && port_rd));

endmodule

/* logic/mem_paging.sv */
//////////////////////////////////////////////////
// 7FFD and EFF7 memory paging registers
// pentagon 1m lock and masking
//////////////////////////////////////////////////
module mem_paging import zports_pkg::*; (
	input  logic       zclk,
	input  logic       rst_n,
	input  zbus_t      bus,
	input  port_sel_e  sel,
	input  logic       port_wr,
	input  logic [7:0] din,
	output mem_cfg_t   cfg
);

	logic [7:0] p7ffd_q; // 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 1m page
	logic [7:0] peff7_q; // 2 block 1m, 3 ram at 0
	logic       block1m;
	logic       block7ffd;
	logic       wr_7ffd, wr_eff7;

	assign block1m   = peff7_q[2];
	assign block7ffd = p7ffd_q[5] & block1m; // 48k lock only without 1m

	assign wr_7ffd = port_wr && (sel == PS_FD) && !bus.a[15] && !block7ffd;
	assign wr_eff7 = port_wr && (sel == PS_F7) && bus.a[8] && !bus.a[12];

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= 8'h00;
			peff7_q <= 8'h00;
		end
		else
		begin
			if (wr_7ffd)
				p7ffd_q <= din;
			if (wr_eff7)
				peff7_q <= din;
		end
	end

	// exported views, masked in 128k mode
	assign cfg.p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};
	assign cfg.peff7 = block1m ?
		{peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;

	assign cfg.page   = {p7ffd_q[7:5], p7ffd_q[2:0]};
	assign cfg.rom    = p7ffd_q[4];
	assign cfg.on_1m  = ~peff7_q[2];
	assign cfg.ram0_0 = peff7_q[3];

endmodule

/* logic/port_decode.sv */
//////////////////////////////////////////////////
// Port address decoder
// low address byte to port select, hit and drive
//////////////////////////////////////////////////
module port_decode import zports_pkg::*; (
	input  zbus_t     bus,
	output port_sel_e sel,
	output logic      porthit,
	output logic      dataout
);

	logic [7:0] loa; // low address byte
	logic       ext_port; // read driven by someone else

	assign loa = bus.a[7:0];

	//////////////////////////////////////////////////
	// select
	//////////////////////////////////////////////////
	always_comb
	begin
		case (loa)
			PORT_FE: sel = PS_FE;
			PORT_FD: sel = PS_FD;
			PORT_F7: sel = PS_F7; // a[8], a[12] checked by paging
			IDE_10:  sel = PS_IDE_LO;
			IDE_11:  sel = PS_IDE_HI;
			IDE_30, IDE_50, IDE_70, IDE_90,
			IDE_B0, IDE_D0, IDE_F0, IDE_C8:
				sel = PS_IDE_REG;
			default: sel = PS_NONE;
		endcase
	end

	assign porthit = (sel != PS_NONE); // goes to zxbus iorq gating

	// FFFD read: ay chip puts its own data on the bus
	assign ext_port = (sel == PS_FD) && (bus.a[15:14] == 2'b11);

	// drive data bus only on io read of our own port
	assign dataout = porthit & ~bus.iorq_n & ~bus.rd_n & ~ext_port;

endmodule

/* logic/sound_border.sv */
//////////////////////////////////////////////////
// Border, beeper and AY bus control
//////////////////////////////////////////////////
module sound_border import zports_pkg::*; (
	input  logic       zclk,
	input  logic       rst_n,
	input  zbus_t      bus,
	input  port_sel_e  sel,
	input  logic       port_wr,
	input  logic [7:0] din,
	output logic [2:0] border,
	output logic       beep,
	output logic       ay_bdir,
	output logic       ay_bc1
);

	logic fe_wr;
	logic pre_bc1, pre_bdir; // address part of ay controls

	assign fe_wr = port_wr && (sel == PS_FE);

	always_ff @(posedge zclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= 3'd0;
			beep   <= 1'b0;
		end
		else if (fe_wr)
		begin
			border <= din[2:0];
			beep   <= din[4] ^ din[3]; // speaker and tape out share one pin
		end
	end

	// FFFD: address/read, BFFD: data write
	assign pre_bc1  = (sel == PS_FD) && (bus.a[15:14] == 2'b11);
	assign pre_bdir = (sel == PS_FD) && bus.a[15];

	assign ay_bc1  = pre_bc1 & ~bus.iorq_n & (~bus.rd_n | ~bus.wr_n);
	assign ay_bdir = pre_bdir & ~bus.iorq_n & ~bus.wr_n; // writes only

endmodule

/* logic/zports_pkg.sv */
//////////////////////////////////////////////////
// Z80 port block shared definitions
// port numbers, decoded select and bus structs
//////////////////////////////////////////////////
package zports_pkg;

	// low address byte of each port
	localparam logic [7:0] PORT_FE = 8'hFE; // border, beep, keyboard
	localparam logic [7:0] PORT_FD = 8'hFD; // 7FFD paging and AY
	localparam logic [7:0] PORT_F7 = 8'hF7; // EFF7 paging

	// IDE, nemo layout
	localparam logic [7:0] IDE_10 = 8'h10; // data low
	localparam logic [7:0] IDE_11 = 8'h11; // data high, not a drive register
	localparam logic [7:0] IDE_30 = 8'h30;
	localparam logic [7:0] IDE_50 = 8'h50;
	localparam logic [7:0] IDE_70 = 8'h70;
	localparam logic [7:0] IDE_90 = 8'h90;
	localparam logic [7:0] IDE_B0 = 8'hB0;
	localparam logic [7:0] IDE_D0 = 8'hD0;
	localparam logic [7:0] IDE_F0 = 8'hF0;
	localparam logic [7:0] IDE_C8 = 8'hC8; // control block, goes on cs1

	localparam logic [7:0] IDLE_BYTE = 8'hFF; // floating bus value

	// decoded port
	typedef enum logic [2:0] {
		PS_NONE,
		PS_FE,
		PS_FD,
		PS_F7,
		PS_IDE_LO,  // 10
		PS_IDE_HI,  // 11
		PS_IDE_REG  // 30..F0, C8
	} port_sel_e;

	// z80 side
	typedef struct packed {
		logic [15:0] a;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
	} zbus_t;

	// ide drive control lines
	typedef struct packed {
		logic [2:0] ide_a;
		logic       cs0_n;
		logic       cs1_n;
		logic       rd_n;
		logic       wr_n;
		logic       dataout_n; // low: drive data flows toward the fpga
	} ide_ctl_t;

	// memory paging state as seen by the pager
	typedef struct packed {
		logic [7:0] p7ffd;  // after 1m masking
		logic [7:0] peff7;  // after 1m masking
		logic       ram0_0; // ram in 0000..3FFF
		logic       on_1m;  // 1 megabyte extension active
		logic [5:0] page;   // full page number
		logic       rom;    // rom half select
	} mem_cfg_t;

endpackage

/* logic/zports_top.sv */
//////////////////////////////////////////////////
// Z80 I/O port block top
// wires the port blocks and the read-back mux
//////////////////////////////////////////////////
module zports_top import zports_pkg::*; (
	input  logic        zclk,
	input  logic        rst_n,
	input  zbus_t       bus,
	input  logic [7:0]  din,
	input  logic [15:0] idein,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	output logic [7:0]  dout,
	output logic        porthit,
	output logic        dataout,
	output logic [2:0]  border,
	output logic        beep,
	output logic        ay_bdir,
	output logic        ay_bc1,
	output ide_ctl_t    ide,
	output logic [15:0] ideout,
	output mem_cfg_t    cfg
);

	logic      port_wr, port_rd; // one-cycle strobes
	port_sel_e sel;
	logic [7:0] ide_rd_data;

	io_cycle_detect u_cycle (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.bus     (bus),
		.port_wr (port_wr),
		.port_rd (port_rd)
	);

	port_decode u_decode (
		.bus     (bus),
		.sel     (sel),
		.porthit (porthit),
		.dataout (dataout)
	);

	sound_border u_snd (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.bus     (bus),
		.sel     (sel),
		.port_wr (port_wr),
		.din     (din),
		.border  (border),
		.beep    (beep),
		.ay_bdir (ay_bdir),
		.ay_bc1  (ay_bc1)
	);

	ide_bridge u_ide (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.bus     (bus),
		.sel     (sel),
		.port_wr (port_wr),
		.port_rd (port_rd),
		.din     (din),
		.idein   (idein),
		.ide     (ide),
		.ideout  (ideout),
		.rd_data (ide_rd_data)
	);

	mem_paging u_mem (
		.zclk    (zclk),
		.rst_n   (rst_n),
		.bus     (bus),
		.sel     (sel),
		.port_wr (port_wr),
		.din     (din),
		.cfg     (cfg)
	);

	//////////////////////////////////////////////////
	// read-back mux
	//////////////////////////////////////////////////
	always_comb
	begin
		case (sel)
			PS_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in}; // keyboard half-row + tape
			PS_IDE_LO, PS_IDE_HI, PS_IDE_REG:
				dout = ide_rd_data;
			default:
				dout = IDLE_BYTE; // FD, F7 and unknown ports
		endcase
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -f compile.f --top-module tb_zports \
	-Mdir obj_dir -o tb_zports_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_zports_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx "=== PASS ===" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb/tb_zports.sv */
//////////////////////////////////////////////////
// testbench for the Z80 I/O port block
// directed bus cycles checked against port rules
//////////////////////////////////////////////////
module tb_zports import zports_pkg::*; ();

	logic        zclk;
	logic        rst_n;
	zbus_t       bus;
	logic [7:0]  din;
	logic [15:0] idein;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [7:0]  dout;
	logic        porthit, dataout;
	logic [2:0]  border;
	logic        beep, ay_bdir, ay_bc1;
	ide_ctl_t    ide;
	logic [15:0] ideout;
	mem_cfg_t    cfg;

	integer      seed;
	logic [7:0]  p7_model, pe_model; // expected paging registers

	// outputs captured mid-cycle, after the strobe edge
	logic [7:0]  snap_dout;
	logic        snap_porthit, snap_dataout, snap_bdir, snap_bc1;
	ide_ctl_t    snap_ide;
	logic [15:0] snap_ideout;

	localparam int IDLE_TIMEOUT = 8; // negedges allowed for bus release

	zports_top dut (.*);

	initial zclk = 1'b0;
	always #10 zclk = ~zclk; // 20 unit period

	//////////////////////////////////////////////////
	// reporting and compare
	//////////////////////////////////////////////////
	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: %s expected %h got %h",
				$time, what, exp, got));
	endtask

	task automatic check_word(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: %s expected %h got %h",
				$time, what, exp, got));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: %s expected %b got %b",
				$time, what, exp, got));
	endtask

	task automatic check_ide(input string what, input ide_ctl_t got, input ide_ctl_t exp);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: %s ide lines expected %b got %b",
				$time, what, exp, got));
	endtask

	task automatic check_mem(input string what, input mem_cfg_t got, input mem_cfg_t exp);
		if (got !== exp)
			report_error($sformatf("Mismatch at %0t: %s cfg expected %h got %h",
				$time, what, exp, got));
	endtask

	// drive lines, dataout_n follows a drive read
	function automatic ide_ctl_t make_ide(input logic [2:0] ra, input logic cs0_n,
		input logic cs1_n, input logic rd_n, input logic wr_n);
		ide_ctl_t c;
		c.ide_a     = ra;
		c.cs0_n     = cs0_n;
		c.cs1_n     = cs1_n;
		c.rd_n      = rd_n;
		c.wr_n      = wr_n;
		c.dataout_n = rd_n;
		return c;
	endfunction

	// paging view from the raw register values
	function automatic mem_cfg_t expected_mem(input logic [7:0] p7, input logic [7:0] pe);
		mem_cfg_t c;
		c.p7ffd  = pe[2] ? {3'b000, p7[4:0]} : p7; // 1m page bits hidden
		c.peff7  = pe[2] ? (pe & ~8'h4E) : pe;     // bits 6,3,2,1
		c.ram0_0 = pe[3];
		c.on_1m  = ~pe[2];
		c.page   = {p7[7:5], p7[2:0]};
		c.rom    = p7[4];
		return c;
	endfunction

	//////////////////////////////////////////////////
	// bus cycles
	//////////////////////////////////////////////////
	task automatic tick(input int n);
		repeat (n) @(posedge zclk);
		@(negedge zclk); // settle point
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge zclk);
		while (dataout || ay_bdir || ay_bc1 || !ide.rd_n || !ide.wr_n)
		begin
			if (n == IDLE_TIMEOUT)
				report_error("timeout: the DUT kept driving the bus after the cycle ended");
			else
			begin
				n++;
				@(negedge zclk);
			end
		end
	endtask

	// active for 3 edges, then released for 2
	task automatic bus_cycle(input logic [15:0] addr, input logic is_wr, input logic [7:0] data);
		@(posedge zclk);
		bus.a      <= addr;
		bus.iorq_n <= 1'b0;
		bus.rd_n   <= is_wr;
		bus.wr_n   <= ~is_wr;
		din        <= data;
		tick(2); // strobe edge passed
		snap_dout    = dout;
		snap_porthit = porthit;
		snap_dataout = dataout;
		snap_bdir    = ay_bdir;
		snap_bc1     = ay_bc1;
		snap_ide     = ide;
		snap_ideout  = ideout;
		@(posedge zclk);
		bus.iorq_n <= 1'b1;
		bus.rd_n   <= 1'b1;
		bus.wr_n   <= 1'b1;
		wait_idle();
		tick(2);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(addr, 1'b1, data);
	endtask

	task automatic io_read(input logic [15:0] addr);
		bus_cycle(addr, 1'b0, 8'h00);
	endtask

	task automatic set_idein(input logic [15:0] w);
		@(posedge zclk);
		idein <= w;
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////
	task automatic write_7ffd(input logic [7:0] d);
		io_write(16'h7FFD, d);
		if (!(p7_model[5] && pe_model[2])) // locked in 128k mode
			p7_model = d;
		check_mem("7ffd write", cfg, expected_mem(p7_model, pe_model));
	endtask

	task automatic write_eff7(input logic [7:0] d);
		io_write(16'hEFF7, d);
		pe_model = d;
		check_mem("eff7 write", cfg, expected_mem(p7_model, pe_model));
	endtask

	task automatic test_paging();
		logic [31:0] r;
		check_mem("after reset", cfg, expected_mem(p7_model, pe_model)); // 1m on
		r = $random(seed);
		write_7ffd(r[7:0] | 8'h20); // lock bit, not active yet
		write_eff7(r[15:8] | 8'h04); // 1m off, lock now active
		write_7ffd(~p7_model); // refused
	endtask

	task automatic test_fe_port();
		logic [31:0] r;
		int          i;
		for (i = 0; i < 4; i++)
		begin
			r = $random(seed);
			io_write(16'h00FE, r[7:0]);
			check_byte("border", {5'b0, border}, {5'b0, r[2:0]});
			check_bit("beep", beep, r[4] ^ r[3]);
		end
		r = $random(seed);
		@(posedge zclk);
		keys_in   <= r[4:0];
		tape_read <= r[5];
		io_read(16'hFEFE);
		check_byte("fe read", snap_dout, {1'b1, r[5], 1'b0, r[4:0]});
		check_bit("fe dataout", snap_dataout, 1'b1);
		check_bit("fe porthit", snap_porthit, 1'b1);
		io_read(16'h0042); // nobody lives here
		check_bit("unknown porthit", snap_porthit, 1'b0);
		check_bit("unknown dataout", snap_dataout, 1'b0);
		check_byte("unknown read", snap_dout, 8'hFF);
	endtask

	task automatic test_ay();
		io_read(16'hFFFD); // register read, chip drives data
		check_bit("fffd read bc1", snap_bc1, 1'b1);
		check_bit("fffd read bdir", snap_bdir, 1'b0);
		check_bit("fffd read dataout", snap_dataout, 1'b0);
		io_write(16'hFFFD, 8'h07); // address latch
		check_bit("fffd write bc1", snap_bc1, 1'b1);
		check_bit("fffd write bdir", snap_bdir, 1'b1);
		io_write(16'hBFFD, 8'h3F); // data write
		check_bit("bffd write bc1", snap_bc1, 1'b0);
		check_bit("bffd write bdir", snap_bdir, 1'b1);
		check_bit("idle bc1", ay_bc1, 1'b0);
		check_bit("idle bdir", ay_bdir, 1'b0);
	endtask

	task automatic test_ide_normal();
		logic [31:0] r;
		r = $random(seed);
		set_idein(r[15:0]);
		io_read(16'h0010);
		check_byte("ide 10 read", snap_dout, r[7:0]);
		check_ide("ide 10 read", snap_ide, make_ide(3'b000, 1'b0, 1'b1, 1'b0, 1'b1));
		set_idein(~r[15:0]); // high byte must come from the latch
		io_read(16'h0011);
		check_byte("ide 11 read", snap_dout, r[15:8]);
		check_ide("ide 11 read", snap_ide, make_ide(3'b000, 1'b1, 1'b1, 1'b1, 1'b1));
		io_write(16'h0011, r[23:16]); // high half first
		check_ide("ide 11 write", snap_ide, make_ide(3'b000, 1'b1, 1'b1, 1'b1, 1'b1));
		io_write(16'h0010, r[31:24]);
		check_ide("ide 10 write", snap_ide, make_ide(3'b000, 1'b0, 1'b1, 1'b1, 1'b0));
		check_word("ide word out", snap_ideout, {r[23:16], r[31:24]});
	endtask

	task automatic test_ide_divide();
		logic [31:0] r;
		r = $random(seed);
		set_idein(r[15:0]);
		io_read(16'h0010);
		check_byte("divide 1st read", snap_dout, r[7:0]);
		check_ide("divide 1st read", snap_ide, make_ide(3'b000, 1'b0, 1'b1, 1'b0, 1'b1));
		set_idein(~r[15:0]);
		io_read(16'h0010); // no drive access
		check_byte("divide 2nd read", snap_dout, r[15:8]);
		check_ide("divide 2nd read", snap_ide, make_ide(3'b000, 1'b0, 1'b1, 1'b1, 1'b1));
		io_write(16'h0010, r[23:16]); // low byte parked
		check_ide("divide 1st write", snap_ide, make_ide(3'b000, 1'b0, 1'b1, 1'b1, 1'b1));
		io_write(16'h0010, r[31:24]);
		check_ide("divide 2nd write", snap_ide, make_ide(3'b000, 1'b0, 1'b1, 1'b1, 1'b0));
		check_word("divide word out", snap_ideout, {r[31:24], r[23:16]});
		set_idein(r[31:16]);
		io_read(16'h00C8); // control block on cs1
		check_ide("c8 read", snap_ide, make_ide(3'b110, 1'b1, 1'b0, 1'b0, 1'b1));
		check_byte("c8 read", snap_dout, r[23:16]);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial
	begin
		seed       = 32'h7cda8bf3;
		p7_model   = 8'h00;
		pe_model   = 8'h00;
		rst_n      = 1'b0;
		bus.a      = 16'h0000;
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
		din        = 8'h00;
		idein      = 16'h0000;
		keys_in    = 5'h1F; // no key down
		tape_read  = 1'b0;
		repeat (4) @(posedge zclk);
		rst_n <= 1'b1;
		@(negedge zclk);
		test_paging();
		test_fe_port();
		test_ay();
		test_ide_normal();
		test_ide_divide();
		$display("=== PASS ===");
		$finish;
	end

endmodule
